//--- source/ghash_config.svh
`ifndef GHASH_CONFIG_SVH
`define GHASH_CONFIG_SVH

// number of hash lanes, power of two from 1 to 8
`define GHASH_LANES 4

// command buffer entries per lane, also the dispatcher's starting credit
`define GHASH_LANE_DEPTH 2

// multiplier bits handled per cycle, must divide 128
`define GHASH_DIGIT 8

`endif

//--- source/ghash_pkg.sv
`include "ghash_config.svh"

package ghash_pkg;

    // at least one bit, even for a single lane
    localparam int LANE_W = (`GHASH_LANES > 1) ? $clog2(`GHASH_LANES) : 1;

    // gcm order, bit 0 is the x^0 coefficient and the most significant bit
    typedef logic [0:127] block_t;

    typedef logic [LANE_W-1:0] lane_t;

    typedef enum logic [1:0] {
        op_start = 2'd0,    // load h, clear y
        op_block = 2'd1,    // y = (y ^ x) * h
        op_final = 2'd2     // emit y as tag
    } ghash_op_e;

    typedef enum logic [1:0] {
        idle,               // ready for next command
        mult,               // multiplier running
        emit                // waiting for a tag credit
    } lane_state_e;

endpackage

//--- source/ghash_cmd_if.sv
`timescale 1ns/1ps

interface ghash_cmd_if;
    import ghash_pkg::*;

    logic      cmd_valid;    // one command this cycle
    ghash_op_e cmd_op;
    block_t    cmd_data;
    logic      cmd_credit;   // lane freed one buffer entry

    modport dispatch (
        output cmd_valid,
        output cmd_op,
        output cmd_data,
        input  cmd_credit
    );

    modport lane (
        input  cmd_valid,
        input  cmd_op,
        input  cmd_data,
        output cmd_credit
    );

endinterface

//--- source/gf128_mul.sv
`timescale 1ns/1ps
`include "ghash_config.svh"

module gf128_mul (
    input  logic              clk_out,
    input  logic              rst,
    input  logic              start,
    input  ghash_pkg::block_t a,
    input  ghash_pkg::block_t b,
    input  ghash_pkg::block_t h,
    output logic              busy,
    output logic              done,
    output ghash_pkg::block_t p
);
    import ghash_pkg::*;

    localparam int     DIGIT = `GHASH_DIGIT;
    localparam int     STEPS = 128 / DIGIT;
    localparam int     CW    = $clog2(STEPS + 1);
    localparam block_t R     = 128'hE1000000000000000000000000000000;  // x^7+x^2+x+1

    block_t        x_q;      // multiplier bits left, next one at bit 0
    block_t        v_q;      // h times x^k
    block_t        z_q;      // partial product
    logic [CW-1:0] step_q;   // digits already processed
    block_t        src_x;
    block_t        src_v;
    block_t        src_z;
    block_t        nxt_x;
    block_t        nxt_v;
    block_t        nxt_z;

    // first digit is taken straight from the inputs in the start cycle
    always_comb
    begin
        src_x = start ? (a ^ b) : x_q;
        src_v = start ? h : v_q;
        src_z = start ? '0 : z_q;
        nxt_z = src_z;
        nxt_v = src_v;
        for (int i = 0; i < DIGIT; i++)
        begin
            if (src_x[i])
                nxt_z = nxt_z ^ nxt_v;
            if (nxt_v[127])
                nxt_v = (nxt_v >> 1) ^ R;   // x^128 folds back
            else
                nxt_v = nxt_v >> 1;
        end
        nxt_x = src_x << DIGIT;            // consumed bits drop off the top
    end

    always_ff @(posedge clk_out)
    begin
        if (start || busy)
        begin
            x_q <= nxt_x;
            v_q <= nxt_v;
            z_q <= nxt_z;
        end
    end

    always_ff @(posedge clk_out)
    begin
        if (rst)
        begin
            busy   <= 1'b0;
            done   <= 1'b0;
            step_q <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                step_q <= CW'(1);
                if (STEPS == 1)
                    done <= 1'b1;      // whole product in one cycle
                else
                    busy <= 1'b1;
            end
            else if (busy)
            begin
                step_q <= step_q + 1'b1;
                if (step_q == CW'(STEPS - 1))
                begin
                    busy <= 1'b0;      // last digit this cycle
                    done <= 1'b1;
                end
            end
        end
    end

    assign p = z_q;

endmodule

//--- source/ghash_lane.sv
`timescale 1ns/1ps
`include "ghash_config.svh"

module ghash_lane (
    input  logic              clk_out,
    input  logic              rst,
    ghash_cmd_if.lane         cmd,
    output logic              tag_valid,
    output ghash_pkg::block_t tag_data,
    input  logic              tag_credit
);
    import ghash_pkg::*;

    localparam int DEPTH = `GHASH_LANE_DEPTH;
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    ghash_op_e     buf_op   [DEPTH];
    block_t        buf_data [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          pop;
    ghash_op_e     head_op;
    block_t        head_data;

    lane_state_e   state;
    block_t        h_q;          // hash key
    block_t        y_q;          // accumulator
    block_t        cur_data;     // block being hashed
    logic          tag_cred_q;
    logic          mul_start;
    logic          mul_done;
    block_t        mul_p;

    function automatic logic [AW-1:0] bump(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign head_op        = buf_op[rd_ptr];
    assign head_data      = buf_data[rd_ptr];
    assign pop            = (state == idle) && (count != '0);
    assign cmd.cmd_credit = pop;   // entry freed in the pop cycle

    always_ff @(posedge clk_out)
    begin
        if (cmd.cmd_valid)
        begin
            buf_op[wr_ptr]   <= cmd.cmd_op;
            buf_data[wr_ptr] <= cmd.cmd_data;
        end
    end

    always_ff @(posedge clk_out)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (cmd.cmd_valid)
                wr_ptr <= bump(wr_ptr);
            if (pop)
                rd_ptr <= bump(rd_ptr);
            count <= count + CW'(cmd.cmd_valid) - CW'(pop);  // credits keep this in range
        end
    end

    // key and operand capture
    always_ff @(posedge clk_out)
    begin
        if (pop && head_op == op_start)
            h_q <= head_data;
        if (pop && head_op == op_block)
            cur_data <= head_data;
    end

    always_ff @(posedge clk_out)
    begin
        if (rst)
        begin
            state      <= idle;
            y_q        <= '0;
            mul_start  <= 1'b0;
            tag_cred_q <= 1'b1;
        end
        else
        begin
            mul_start <= 1'b0;
            if (tag_credit)
                tag_cred_q <= 1'b1;
            else if (tag_valid)
                tag_cred_q <= 1'b0;
            case (state)
                idle:
                begin
                    if (pop)
                    begin
                        case (head_op)
                            op_start: y_q <= '0;
                            op_block:
                            begin
                                mul_start <= 1'b1;   // multiplier starts next cycle
                                state     <= mult;
                            end
                            op_final: state <= emit;
                            default:  state <= idle;
                        endcase
                    end
                end
                mult:
                begin
                    if (mul_done)
                    begin
                        y_q   <= mul_p;
                        state <= idle;
                    end
                end
                emit:
                begin
                    if (tag_cred_q)
                        state <= idle;       // tag handed off and y kept
                end
                default: state <= idle;
            endcase
        end
    end

    assign tag_valid = (state == emit) && tag_cred_q;
    assign tag_data  = y_q;

    gf128_mul mul0 (
        .clk_out (clk_out),
        .rst     (rst),
        .start   (mul_start),
        .a       (y_q),
        .b       (cur_data),
        .h       (h_q),
        .busy    (),
        .done    (mul_done),
        .p       (mul_p)
    );

endmodule

//--- source/ghash_dispatch.sv
`timescale 1ns/1ps
`include "ghash_config.svh"

module ghash_dispatch (
    input  logic                 clk_out,
    input  logic                 rst,
    input  logic                 in_valid,
    input  ghash_pkg::ghash_op_e in_op,
    input  ghash_pkg::lane_t     in_lane,
    input  ghash_pkg::block_t    in_data,
    output logic                 in_ready,
    ghash_cmd_if.dispatch        lanes [`GHASH_LANES]
);
    import ghash_pkg::*;

    localparam int LANES = `GHASH_LANES;
    localparam int DEPTH = `GHASH_LANE_DEPTH;
    localparam int CW    = $clog2(DEPTH + 1);

    logic [CW-1:0]    credit [LANES];   // free buffer entries per lane
    logic [LANES-1:0] send_q;
    logic [LANES-1:0] back;
    ghash_op_e        op_q;
    block_t           data_q;
    logic             accept;

    assign in_ready = (credit[in_lane] != '0);
    assign accept   = in_valid && in_ready;

    // command payload shared by all links, only the valid is per lane
    always_ff @(posedge clk_out)
    begin
        if (accept)
        begin
            op_q   <= in_op;
            data_q <= in_data;
        end
    end

    always_ff @(posedge clk_out)
    begin
        if (rst)
        begin
            send_q <= '0;
            for (int l = 0; l < LANES; l++)
                credit[l] <= CW'(DEPTH);
        end
        else
        begin
            for (int l = 0; l < LANES; l++)
            begin
                send_q[l] <= accept && (in_lane == lane_t'(l));
                // spend and refill may land in the same cycle
                credit[l] <= credit[l] + CW'(back[l])
                           - CW'(accept && (in_lane == lane_t'(l)));
            end
        end
    end

    for (genvar l = 0; l < LANES; l++)
    begin : g_link
        assign back[l]           = lanes[l].cmd_credit;
        assign lanes[l].cmd_valid = send_q[l];
        assign lanes[l].cmd_op    = op_q;
        assign lanes[l].cmd_data  = data_q;
    end

endmodule

//--- source/ghash_collect.sv
`timescale 1ns/1ps
`include "ghash_config.svh"

module ghash_collect (
    input  logic                    clk_out,
    input  logic                    rst,
    input  logic [`GHASH_LANES-1:0] lane_valid,
    input  ghash_pkg::block_t       lane_data [`GHASH_LANES],
    output logic [`GHASH_LANES-1:0] lane_credit,
    output logic                    tag_valid,
    output ghash_pkg::lane_t        tag_lane,
    output ghash_pkg::block_t       tag_data,
    input  logic                    tag_ready
);
    import ghash_pkg::*;

    localparam int LANES = `GHASH_LANES;

    logic [LANES-1:0] full_q;
    block_t           slot_q [LANES];
    lane_t            rr_q;        // last lane served
    lane_t            out_lane;
    logic             out_valid;
    logic             xfer;
    logic             pick_found;
    lane_t            pick_lane;

    assign xfer      = out_valid && tag_ready;
    assign tag_valid = out_valid;
    assign tag_lane  = out_lane;
    assign tag_data  = slot_q[out_lane];   // slot stays put while presented

    // next full slot after rr_q, walking back so the nearest one wins
    always_comb
    begin
        int cand;
        pick_found = 1'b0;
        pick_lane  = rr_q;
        for (int i = LANES; i >= 1; i--)
        begin
            cand = (int'(rr_q) + i) % LANES;
            if (full_q[cand])
            begin
                pick_found = 1'b1;
                pick_lane  = lane_t'(cand);
            end
        end
    end

    always_comb
    begin
        for (int l = 0; l < LANES; l++)
            lane_credit[l] = xfer && (out_lane == lane_t'(l));
    end

    always_ff @(posedge clk_out)
    begin
        for (int l = 0; l < LANES; l++)
        begin
            if (lane_valid[l])
                slot_q[l] <= lane_data[l];
        end
    end

    always_ff @(posedge clk_out)
    begin
        if (rst)
        begin
            full_q    <= '0;
            rr_q      <= lane_t'(LANES - 1);   // lane 0 goes first
            out_valid <= 1'b0;
            out_lane  <= '0;
        end
        else
        begin
            for (int l = 0; l < LANES; l++)
            begin
                if (lane_credit[l])
                    full_q[l] <= 1'b0;
                if (lane_valid[l])
                    full_q[l] <= 1'b1;      // only with a credit, so slot is empty
            end
            if (xfer)
            begin
                out_valid <= 1'b0;
                rr_q      <= out_lane;
            end
            else if (!out_valid && pick_found)
            begin
                out_valid <= 1'b1;           // held until tag_ready
                out_lane  <= pick_lane;
            end
        end
    end

endmodule

//--- source/ghash_top.sv
`timescale 1ns/1ps
`include "ghash_config.svh"

module ghash_top (
    input  logic                 clk_out,
    input  logic                 rst,
    input  logic                 in_valid,
    input  ghash_pkg::ghash_op_e in_op,
    input  ghash_pkg::lane_t     in_lane,
    input  ghash_pkg::block_t    in_data,
    output logic                 in_ready,
    output logic                 tag_valid,
    output ghash_pkg::lane_t     tag_lane,
    output ghash_pkg::block_t    tag_data,
    input  logic                 tag_ready
);
    import ghash_pkg::*;

    localparam int LANES = `GHASH_LANES;

    logic [LANES-1:0] lane_valid;
    block_t           lane_data [LANES];
    logic [LANES-1:0] lane_credit;

    ghash_cmd_if cmd_link [LANES] ();   // one command link per lane

    ghash_dispatch dispatch0 (
        .clk_out  (clk_out),
        .rst      (rst),
        .in_valid (in_valid),
        .in_op    (in_op),
        .in_lane  (in_lane),
        .in_data  (in_data),
        .in_ready (in_ready),
        .lanes    (cmd_link)
    );

    for (genvar l = 0; l < LANES; l++)
    begin : g_lane
        ghash_lane lane0 (
            .clk_out    (clk_out),
            .rst        (rst),
            .cmd        (cmd_link[l]),
            .tag_valid  (lane_valid[l]),
            .tag_data   (lane_data[l]),
            .tag_credit (lane_credit[l])
        );
    end

    ghash_collect collect0 (
        .clk_out     (clk_out),
        .rst         (rst),
        .lane_valid  (lane_valid),
        .lane_data   (lane_data),
        .lane_credit (lane_credit),
        .tag_valid   (tag_valid),
        .tag_lane    (tag_lane),
        .tag_data    (tag_data),
        .tag_ready   (tag_ready)
    );

endmodule

//--- testbench/ghash_tb.sv
`timescale 1ns/1ps
`include "ghash_config.svh"

module ghash_tb;
    import ghash_pkg::*;

    localparam int LANES      = `GHASH_LANES;
    localparam int MAX_WORDS  = 512;     // four words per record
    localparam int QDEPTH     = 32;
    localparam int SEND_WAIT  = 400;
    localparam int READY_WAIT = 200;
    localparam int DRAIN_WAIT = 3000;

    logic      clk_out;
    logic      rst;
    logic      in_valid;
    ghash_op_e in_op;
    lane_t     in_lane;
    block_t    in_data;
    logic      in_ready;
    logic      tag_valid;
    lane_t     tag_lane;
    block_t    tag_data;
    logic      tag_ready;

    logic [127:0] rec_mem [MAX_WORDS];
    block_t       exp_tag [LANES][QDEPTH];   // per-lane ring of expected tags
    int           exp_head [LANES];
    int           exp_tail [LANES];
    int           seed         = 21658;
    int           cur_test     = 0;
    int           ready_mode   = 0;          // 0 random, 1 high, 2 held low
    logic         hold_off     = 1'b0;       // lifts a held-low tag_ready for draining
    int           limit_cycles = 0;
    int           mismatches   = 0;
    int           missing      = 0;
    int           unexpected   = 0;
    int           other_errors = 0;
    int           checked      = 0;

    ghash_top dut0 (
        .clk_out   (clk_out),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_op     (in_op),
        .in_lane   (in_lane),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .tag_valid (tag_valid),
        .tag_lane  (tag_lane),
        .tag_data  (tag_data),
        .tag_ready (tag_ready)
    );

    function automatic string test_name(input int num);
        case (num)
            0:       return "reset";
            1:       return "single_block";
            2:       return "multi_block";
            3:       return "four_lanes";
            4:       return "back_pressure";
            5:       return "restart";
            default: return "unknown";
        endcase
    endfunction

    function automatic logic queues_empty();
        for (int l = 0; l < LANES; l++)
        begin
            if (exp_head[l] != exp_tail[l])
                return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic check_value(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected)
        begin
            mismatches++;
            $display("FAIL %s: expected %h, actual %h", what, expected, actual);
        end
    endtask

    task automatic push_expected(input int lane, input block_t tag);
        if (exp_tail[lane] - exp_head[lane] >= QDEPTH)
        begin
            other_errors++;
            $display("expected-tag queue of lane %0d overflowed", lane);
        end
        else
        begin
            exp_tag[lane][exp_tail[lane] % QDEPTH] = tag;
            exp_tail[lane]++;
        end
    endtask

    task automatic take_tag(input int lane, input block_t data);
        string what;
        if (exp_head[lane] == exp_tail[lane])
        begin
            unexpected++;
            $display("tag %h arrived on lane %0d in %s but none was expected",
                     data, lane, test_name(cur_test));
        end
        else
        begin
            what = $sformatf("%s lane %0d tag %0d", test_name(cur_test), lane, exp_head[lane]);
            check_value(what, exp_tag[lane][exp_head[lane] % QDEPTH], data);
            exp_head[lane]++;
            checked++;
        end
    endtask

    // called at rising edge + 5, returns there
    task automatic send_cmd(input int lane, input logic [1:0] op, input block_t data);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        in_lane  = lane_t'(lane);
        in_op    = ghash_op_e'(op);
        in_data  = data;
        @(negedge clk_out);
        while (in_ready !== 1'b1 && waited < SEND_WAIT)
        begin
            @(negedge clk_out);
            waited++;
        end
        if (in_ready !== 1'b1)
        begin
            other_errors++;
            $display("command to lane %0d was not accepted within %0d cycles in %s",
                     lane, SEND_WAIT, test_name(cur_test));
            in_valid = 1'b0;   // command dropped
        end
        @(posedge clk_out);
        #5;
        in_valid = 1'b0;
    endtask

    task automatic check_ready(input int lane, input logic level);
        int waited;
        waited  = 0;
        in_lane = lane_t'(lane);
        @(negedge clk_out);
        while (in_ready !== level && waited < READY_WAIT)
        begin
            @(negedge clk_out);
            waited++;
        end
        check_value($sformatf("%s lane %0d in_ready", test_name(cur_test), lane),
                    128'(level), 128'(in_ready));
        @(posedge clk_out);
        #5;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (!queues_empty() && waited < DRAIN_WAIT)
        begin
            @(negedge clk_out);
            waited++;
        end
        @(posedge clk_out);
        #5;
    endtask

    task automatic apply_reset();
        rst      = 1'b1;
        in_valid = 1'b0;
        repeat (8) @(posedge clk_out);
        #5;
        rst = 1'b0;
        @(negedge clk_out);
        check_value($sformatf("%s tag_valid after reset", test_name(cur_test)),
                    128'h0, 128'(tag_valid));
        @(posedge clk_out);
        #5;
        for (int l = 0; l < LANES; l++)
            check_ready(l, 1'b1);
    endtask

    task automatic start_test(input int num, input int mode);
        hold_off = 1'b1;        // previous test drains first
        wait_drain();
        cur_test   = num;
        ready_mode = mode;
        hold_off   = 1'b0;
        $display("test %0d: %s", num, test_name(num));
    endtask

    task automatic finish_run();
        int total;
        total = mismatches + missing + unexpected + other_errors;
        $display("errors: %0d mismatched, %0d missing, %0d unexpected, %0d other (%0d tags checked)",
                 mismatches, missing, unexpected, other_errors, checked);
        if (total == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    endtask

    initial
    begin
        clk_out = 1'b0;
        forever #50 clk_out = ~clk_out;
    end

    initial
    begin : ready_gen
        logic [31:0] rnd;
        tag_ready = 1'b0;
        forever
        begin
            @(posedge clk_out);
            #5;
            if (ready_mode == 1)
                tag_ready = 1'b1;
            else if (ready_mode == 2 && !hold_off)
                tag_ready = 1'b0;
            else
            begin
                rnd       = $random(seed);
                tag_ready = rnd[0];
            end
        end
    end

    // transfer happens at the next rising edge, values are settled here
    always @(negedge clk_out)
    begin
        if (rst === 1'b0 && tag_valid === 1'b1 && tag_ready === 1'b1)
            take_tag(int'(tag_lane), tag_data);
    end

    initial
    begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk_out);
        other_errors++;
        $display("timeout: run did not finish within %0d cycles", limit_cycles);
        finish_run();
    end

    initial
    begin : main
        int           i;
        int           ncmd;
        logic [127:0] kind;
        logic [127:0] rec_a;
        logic [127:0] rec_b;
        logic [127:0] rec_d;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_op    = op_start;
        in_lane  = '0;
        in_data  = '0;
        $readmemh("testbench/ghash_input.txt", rec_mem);
        ncmd = 0;
        for (i = 0; i + 3 < MAX_WORDS; i += 4)
        begin
            if (rec_mem[i] === 128'h0)
                ncmd++;
        end
        limit_cycles = ncmd * 20 + 2000;
        apply_reset();
        i = 0;
        while (i + 3 < MAX_WORDS && rec_mem[i] !== 128'hf)
        begin
            kind  = rec_mem[i];
            rec_a = rec_mem[i + 1];
            rec_b = rec_mem[i + 2];
            rec_d = rec_mem[i + 3];
            case (kind)
                128'h0:  send_cmd(int'(rec_a), rec_b[1:0], rec_d);
                128'h1:  push_expected(int'(rec_a), rec_d);
                128'h2:  start_test(int'(rec_a), int'(rec_b));
                128'h3:  check_ready(int'(rec_a), rec_b[0]);
                128'h4:  apply_reset();
                default:
                begin
                    other_errors++;
                    $display("bad record kind %h at word %0d of the input file", kind, i);
                    i = MAX_WORDS;
                end
            endcase
            i += 4;
        end
        hold_off = 1'b1;
        wait_drain();
        repeat (20) @(posedge clk_out);   // room for stray tags
        for (int l = 0; l < LANES; l++)
        begin
            if (exp_tail[l] != exp_head[l])
            begin
                missing += exp_tail[l] - exp_head[l];
                $display("lane %0d: %0d expected tags never arrived",
                         l, exp_tail[l] - exp_head[l]);
            end
        end
        finish_run();
    end

endmodule

//--- testbench/ghash_input.txt
// kind lane op data: kind 0 command (op 0 start, 1 block, 2 final), 1 expected tag,
// kind 2 test label (lane = test number, op = tag_ready mode), 3 in_ready check, 4 reset, f end
// test 1, h = x, tag = x times h
2 1 1 0
0 0 0 40000000000000000000000000000000
0 0 1 0123456789abcdef0123456789abcdef
1 0 0 e191a2b3c4d5e6f78091a2b3c4d5e6f7
0 0 2 0
// test 2, gcm test case 2 ghash with length block, final twice
2 2 0 0
0 0 0 66e94bd4ef8a2c3b884cfa59ca342b2e
0 0 1 0388dace60b6a392f328c2b971b2fe78
0 0 1 00000000000000000000000000000080
1 0 0 f38cbb1ad69223dcc3457ae5b6b0f885
0 0 2 0
1 0 0 f38cbb1ad69223dcc3457ae5b6b0f885
0 0 2 0
// test 3, four lanes interleaved, keys gcm h, 1, x^4, x^8
2 3 0 0
0 0 0 66e94bd4ef8a2c3b884cfa59ca342b2e
0 1 0 80000000000000000000000000000000
0 2 0 08000000000000000000000000000000
0 3 0 00800000000000000000000000000000
0 0 1 0388dace60b6a392f328c2b971b2fe78
0 1 1 00112233445566778899aabbccddeeff
0 2 1 00000000000000000000000000000001
0 3 1 abcdef00000000000000000000000000
0 1 1 ffeeddccbbaa99887766554433221100
1 3 0 00abcdef000000000000000000000000
0 3 2 0
1 1 0 ffffffffffffffffffffffffffffffff
0 1 2 0
0 0 1 00000000000000000000000000000080
0 2 1 1c200000000000000000000000000001
0 3 1 00000000000000000000000000000000
0 1 1 0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f
1 2 0 1c200000000000000000000000000000
0 2 2 0
1 0 0 f38cbb1ad69223dcc3457ae5b6b0f885
0 0 2 0
1 3 0 0000abcdef0000000000000000000000
0 3 2 0
1 1 0 f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0f0
0 1 2 0
// test 4, tag_ready held low, lane 2 runs out of credits, lane 1 still accepts
2 4 2 0
0 2 0 00800000000000000000000000000000
0 2 1 11000000000000000000000000000000
1 2 0 00110000000000000000000000000000
0 2 2 0
0 2 1 00220000000000000000000000000000
1 2 0 00003300000000000000000000000000
0 2 2 0
1 2 0 00003300000000000000000000000000
0 2 2 0
1 2 0 00003300000000000000000000000000
0 2 2 0
3 2 0 0
3 1 1 0
0 1 0 80000000000000000000000000000000
0 1 1 5555aaaa5555aaaa5555aaaa5555aaaa
1 1 0 5555aaaa5555aaaa5555aaaa5555aaaa
0 1 2 0
3 2 0 0
// test 5, reset, then start in the middle of a stream
2 5 0 0
4 0 0 0
0 3 0 00800000000000000000000000000000
0 3 1 ff000000000000000000000000000000
1 3 0 00ff0000000000000000000000000000
0 3 2 0
0 3 1 12345678000000000000000000000000
0 3 0 80000000000000000000000000000000
0 3 1 0123456789abcdef0011223344556677
1 3 0 0123456789abcdef0011223344556677
0 3 2 0
f 0 0 0

//--- files.f
+incdir+source
source/ghash_pkg.sv
source/ghash_cmd_if.sv
source/gf128_mul.sv
source/ghash_lane.sv
source/ghash_dispatch.sv
source/ghash_collect.sv
source/ghash_top.sv
testbench/ghash_tb.sv
